// File: source/twiddle_pkg.sv
package twiddle_pkg;

	// ####################
	// widths
	// ####################

	localparam int TW_WIDTH    = 24;  // one twiddle component
	localparam int TW_FRAC     = 8;   // 256 is 1.0
	localparam int SEG_LEN     = 128; // samples per phase
	localparam int QUARTER_LEN = 65;  // cosine entries for m = 0..64

	localparam int IDX_WIDTH = $clog2(SEG_LEN);
	localparam int CNT_WIDTH = IDX_WIDTH + 2; // four phases per frame

	// ####################
	// types
	// ####################

	typedef logic signed [TW_WIDTH-1:0] tw_sample_t;
	typedef logic [CNT_WIDTH-1:0]       count_t;   // position in the 4 x 128 frame
	typedef logic [IDX_WIDTH-1:0]       tw_idx_t;  // k within a phase

	typedef struct packed {
		tw_sample_t re; // upper field
		tw_sample_t im;
	} twiddle_t;

	// order and encodings follow the counter's upper bits
	typedef enum logic [1:0] {
		PH_FILL_A = 2'd0,
		PH_FILL_B = 2'd1,
		PH_ROTATE = 2'd2,
		PH_DRAIN  = 2'd3
	} phase_e;

	// 1 + 0j outside the rotating phase
	localparam tw_sample_t TW_ONE    = tw_sample_t'(1 << TW_FRAC);
	localparam twiddle_t   TW_UNITY  = '{re: TW_ONE, im: '0};

endpackage

// File: source/twiddle_sequencer.sv
module twiddle_sequencer
	import twiddle_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start_i,
	output logic    running_o,
	output phase_e  phase_o,
	output tw_idx_t index_o
);

	count_t count_q;
	count_t count_d;
	logic   running_q;
	logic   advance;

	// ####################
	// sample counter
	// ####################

	// the start edge itself already counts
	assign advance = start_i | running_q;

	always_comb begin
		count_d = count_q;
		if (advance) begin
			count_d = count_q + count_t'(1); // 511 wraps to 0
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_q   <= '0;
			running_q <= 1'b0;
		end else begin
			count_q <= count_d;
			if (start_i) begin
				running_q <= 1'b1; // sticky until reset
			end
		end
	end

	// ####################
	// phase and index split
	// ####################

	always_comb begin
		case (count_q[CNT_WIDTH-1 -: 2])
			2'd0:    phase_o = PH_FILL_A;
			2'd1:    phase_o = PH_FILL_B;
			2'd2:    phase_o = PH_ROTATE;
			default: phase_o = PH_DRAIN;
		endcase
	end

	assign index_o   = count_q[IDX_WIDTH-1:0]; // k = count mod 128
	assign running_o = running_q;

endmodule

// File: source/twiddle_rom.sv
module twiddle_rom
	import twiddle_pkg::*;
(
	input  phase_e   phase_i,
	input  tw_idx_t  index_i,
	output twiddle_t twiddle_o
);

	localparam int QIDX_WIDTH = $clog2(QUARTER_LEN);

	typedef logic [QIDX_WIDTH-1:0] qidx_t; // address into the quarter-wave table
	typedef logic [TW_FRAC:0]      mag_t;  // unsigned magnitude up to 256

	localparam tw_idx_t HALF_IDX = tw_idx_t'(QUARTER_LEN - 1); // k = 64 is pi/2

	qidx_t      re_addr;
	qidx_t      im_addr;
	logic       re_neg;
	mag_t       re_mag;
	mag_t       im_mag;
	tw_sample_t re_val;
	tw_sample_t im_val;

	// ####################
	// quarter-wave table
	// ####################

	// round(cos(pi*m/128) * 256)
	function automatic mag_t cos_mag(input qidx_t m);
		case (m)
			7'd0:    cos_mag = 9'd256;
			7'd1:    cos_mag = 9'd256;
			7'd2:    cos_mag = 9'd256;
			7'd3:    cos_mag = 9'd255;
			7'd4:    cos_mag = 9'd255;
			7'd5:    cos_mag = 9'd254;
			7'd6:    cos_mag = 9'd253;
			7'd7:    cos_mag = 9'd252;
			7'd8:    cos_mag = 9'd251;
			7'd9:    cos_mag = 9'd250;
			7'd10:   cos_mag = 9'd248;
			7'd11:   cos_mag = 9'd247;
			7'd12:   cos_mag = 9'd245;
			7'd13:   cos_mag = 9'd243;
			7'd14:   cos_mag = 9'd241;
			7'd15:   cos_mag = 9'd239;
			7'd16:   cos_mag = 9'd237;
			7'd17:   cos_mag = 9'd234;
			7'd18:   cos_mag = 9'd231;
			7'd19:   cos_mag = 9'd229;
			7'd20:   cos_mag = 9'd226;
			7'd21:   cos_mag = 9'd223;
			7'd22:   cos_mag = 9'd220;
			7'd23:   cos_mag = 9'd216;
			7'd24:   cos_mag = 9'd213;
			7'd25:   cos_mag = 9'd209;
			7'd26:   cos_mag = 9'd206;
			7'd27:   cos_mag = 9'd202;
			7'd28:   cos_mag = 9'd198;
			7'd29:   cos_mag = 9'd194;
			7'd30:   cos_mag = 9'd190;
			7'd31:   cos_mag = 9'd185;
			7'd32:   cos_mag = 9'd181; // pi/4
			7'd33:   cos_mag = 9'd177;
			7'd34:   cos_mag = 9'd172;
			7'd35:   cos_mag = 9'd167;
			7'd36:   cos_mag = 9'd162;
			7'd37:   cos_mag = 9'd157;
			7'd38:   cos_mag = 9'd152;
			7'd39:   cos_mag = 9'd147;
			7'd40:   cos_mag = 9'd142;
			7'd41:   cos_mag = 9'd137;
			7'd42:   cos_mag = 9'd132;
			7'd43:   cos_mag = 9'd126;
			7'd44:   cos_mag = 9'd121;
			7'd45:   cos_mag = 9'd115;
			7'd46:   cos_mag = 9'd109;
			7'd47:   cos_mag = 9'd104;
			7'd48:   cos_mag = 9'd98;
			7'd49:   cos_mag = 9'd92;
			7'd50:   cos_mag = 9'd86;
			7'd51:   cos_mag = 9'd80;
			7'd52:   cos_mag = 9'd74;
			7'd53:   cos_mag = 9'd68;
			7'd54:   cos_mag = 9'd62;
			7'd55:   cos_mag = 9'd56;
			7'd56:   cos_mag = 9'd50;
			7'd57:   cos_mag = 9'd44;
			7'd58:   cos_mag = 9'd38;
			7'd59:   cos_mag = 9'd31;
			7'd60:   cos_mag = 9'd25;
			7'd61:   cos_mag = 9'd19;
			7'd62:   cos_mag = 9'd13;
			7'd63:   cos_mag = 9'd6;
			7'd64:   cos_mag = 9'd0;
			default: cos_mag = '0; // m > 64 never addressed
		endcase
	endfunction

	// ####################
	// index folding
	// ####################

	always_comb begin
		re_neg = (index_i > HALF_IDX); // second quadrant of the half turn
		if (re_neg) begin
			re_addr = qidx_t'(SEG_LEN - int'(index_i));
			im_addr = qidx_t'(index_i - HALF_IDX);
		end else begin
			re_addr = qidx_t'(index_i);
			im_addr = qidx_t'(HALF_IDX - index_i);
		end
	end

	assign re_mag = cos_mag(re_addr);
	assign im_mag = cos_mag(im_addr); // sin(pi*k/128) = cos(pi*|64-k|/128)

	// zero-extend the magnitude before the sign
	assign re_val = re_neg ? -tw_sample_t'(re_mag) : tw_sample_t'(re_mag);
	assign im_val = -tw_sample_t'(im_mag); // always on or below the real axis

	// ####################
	// output select
	// ####################

	always_comb begin
		if (phase_i == PH_ROTATE) begin
			twiddle_o.re = re_val;
			twiddle_o.im = im_val;
		end else begin
			twiddle_o = TW_UNITY; // fill and drain pass samples unrotated
		end
	end

endmodule

// File: source/fft128_twiddle_gen.sv
module fft128_twiddle_gen
	import twiddle_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start_i,
	output logic     running_o,
	output phase_e   phase_o,
	output twiddle_t twiddle_o
);

	tw_idx_t tw_index; // k within the current phase

	// ####################
	// counter and phase
	// ####################

	twiddle_sequencer u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (start_i),
		.running_o (running_o),
		.phase_o   (phase_o),
		.index_o   (tw_index)
	);

	// ####################
	// twiddle lookup
	// ####################

	// combinational lookup in the counter's cycle
	twiddle_rom u_rom (
		.phase_i   (phase_o),
		.index_i   (tw_index),
		.twiddle_o (twiddle_o)
	);

endmodule

// File: sim/fft128_twiddle_gen_assertions.sv
module fft128_twiddle_gen_assertions
	import twiddle_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     running_o,
	input phase_e   phase_o,
	input twiddle_t twiddle_o
);

	int         fail_count = 0;
	logic [1:0] phase_next;

	assign phase_next = phase_o + 2'd1; // PH_DRAIN wraps to PH_FILL_A

	// ####################
	// port properties
	// ####################

	running_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		running_o |=> running_o)
	else begin
		$error("running_o fell while out of reset");
		fail_count++;
	end

	phase_order: assert property (@(posedge clk) disable iff (!rst_n)
		(phase_o == $past(phase_o)) || (phase_o == $past(phase_next)))
	else begin
		$error("phase_o skipped or went backwards");
		fail_count++;
	end

	unity_outside_rotate: assert property (@(posedge clk) disable iff (!rst_n)
		(phase_o != PH_ROTATE) |-> (twiddle_o.re == 24'sd256 && twiddle_o.im == 24'sd0))
	else begin
		$error("twiddle_o is not 1 + 0j outside PH_ROTATE");
		fail_count++;
	end

	idle_phase: assert property (@(posedge clk) disable iff (!rst_n)
		!running_o |-> (phase_o == PH_FILL_A))
	else begin
		$error("phase_o left PH_FILL_A before start");
		fail_count++;
	end

endmodule

bind fft128_twiddle_gen fft128_twiddle_gen_assertions u_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.running_o (running_o),
	.phase_o   (phase_o),
	.twiddle_o (twiddle_o)
);

// File: sim/tb_fft128_twiddle_gen.sv
module tb_fft128_twiddle_gen
	import twiddle_pkg::*;
();

	localparam string DATA_FILE      = "sim/twiddle_testdata.txt";
	localparam int    RESET_CYCLES   = 3;
	localparam int    FRAME_LEN      = 4 * SEG_LEN;
	localparam int    MID_RESET_AT   = 2 * SEG_LEN + SEG_LEN / 2; // middle of PH_ROTATE
	localparam int    RESTART_CYCLES = 64;
	localparam int    MARGIN         = 100;

	logic     clk;
	logic     rst_n;
	logic     start_i;
	logic     running_o;
	phase_e   phase_o;
	twiddle_t twiddle_o;

	tw_sample_t exp_re [SEG_LEN];
	tw_sample_t exp_im [SEG_LEN];

	int idle_cycles;
	int exp_count;
	bit exp_running;
	int error_count;
	int timeout_count;
	int cycle_count;
	int cycle_limit;

	fft128_twiddle_gen dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (start_i),
		.running_o (running_o),
		.phase_o   (phase_o),
		.twiddle_o (twiddle_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ####################
	// checks and model
	// ####################

	task automatic check_value(input string name, input logic [47:0] expected,
			input logic [47:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_outputs();
		logic [1:0] exp_phase;
		int         k;
		tw_sample_t want_re;
		tw_sample_t want_im;
		exp_phase = exp_count / SEG_LEN;
		k = exp_count % SEG_LEN;
		if (exp_phase == 2'd2) begin
			want_re = exp_re[k];
			want_im = exp_im[k];
		end else begin
			want_re = 24'sd256; // 1 + 0j
			want_im = 24'sd0;
		end
		check_value("running_o", exp_running, running_o);
		check_value("phase_o", exp_phase, phase_o);
		check_value("twiddle_o.re", want_re, twiddle_o.re);
		check_value("twiddle_o.im", want_im, twiddle_o.im);
	endtask

	// advance the expected count on one clock edge and compare
	task automatic step();
		@(posedge clk);
		if (!rst_n) begin
			exp_count = 0;
			exp_running = 1'b0;
		end else begin
			if (start_i || exp_running) begin
				exp_count = (exp_count + 1) % FRAME_LEN;
			end
			if (start_i) begin
				exp_running = 1'b1;
			end
		end
		#1;
		check_outputs();
	endtask

	task automatic load_testdata(output bit ok);
		int          fd;
		int          k;
		int          rows;
		bit          idle_seen;
		string       line;
		logic [23:0] re_v;
		logic [23:0] im_v;
		bit          seen [SEG_LEN];
		ok = 1'b0;
		rows = 0;
		idle_seen = 1'b0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: could not open the test data file %s", DATA_FILE);
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#") begin
					if (!idle_seen) begin
						idle_seen = ($sscanf(line, "%d", idle_cycles) == 1);
					end else if ($sscanf(line, "%d %h %h", k, re_v, im_v) == 3) begin
						if (k >= 0 && k < SEG_LEN && !seen[k]) begin
							seen[k] = 1'b1;
							exp_re[k] = re_v;
							exp_im[k] = im_v;
							rows++;
						end
					end
				end
			end
			$fclose(fd);
			ok = idle_seen && (rows == SEG_LEN);
			if (!ok) begin
				$display("ERROR: test data file incomplete, %0d of %0d twiddle rows read",
					rows, SEG_LEN);
				error_count++;
			end
		end
	endtask

	// ####################
	// stimulus
	// ####################

	task automatic run_tests();
		int n;
		repeat (RESET_CYCLES) step();
		rst_n = 1'b1;
		repeat (idle_cycles) step(); // idle with start low
		start_i = 1'b1;
		step();
		for (n = 1; n < 2 * FRAME_LEN; n++) begin
			start_i = (n == FRAME_LEN + SEG_LEN + 17); // stray pulse in the second frame
			step();
		end
		start_i = 1'b0;
		repeat (MID_RESET_AT) step();
		rst_n = 1'b0;
		exp_count = 0;
		exp_running = 1'b0;
		#1;
		check_outputs(); // asynchronous clear before any edge
		repeat (RESET_CYCLES) step();
		rst_n = 1'b1;
		repeat (idle_cycles) step();
		start_i = 1'b1;
		step();
		start_i = 1'b0;
		repeat (RESTART_CYCLES) step();
	endtask

	task automatic report_and_finish();
		int assert_fails;
		assert_fails = dut_i.u_assert.fail_count;
		$display("errors: %0d  timeouts: %0d  assertion failures: %0d",
			error_count, timeout_count, assert_fails);
		if (error_count == 0 && timeout_count == 0 && assert_fails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	initial begin
		bit loaded;
		rst_n = 1'b0;
		start_i = 1'b0;
		error_count = 0;
		timeout_count = 0;
		exp_count = 0;
		exp_running = 1'b0;
		idle_cycles = 0;
		load_testdata(loaded);
		cycle_limit = 2 * RESET_CYCLES + 2 * idle_cycles + 2 * FRAME_LEN + MID_RESET_AT
			+ 1 + RESTART_CYCLES + MARGIN;
		if (loaded) begin
			run_tests();
		end
		report_and_finish();
	end

	// watchdog
	initial begin
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("ERROR: timeout, the run did not finish within %0d cycles", cycle_limit);
		timeout_count++;
		report_and_finish();
	end

endmodule

// File: sim/twiddle_testdata.txt
# first data line: idle cycles before start (decimal)
# then one row per k: k (decimal), expected re and im (24-bit two's complement hex)
8
0 000100 000000
1 000100 FFFFFA
2 000100 FFFFF3
3 0000FF FFFFED
4 0000FF FFFFE7
5 0000FE FFFFE1
6 0000FD FFFFDA
7 0000FC FFFFD4
8 0000FB FFFFCE
9 0000FA FFFFC8
10 0000F8 FFFFC2
11 0000F7 FFFFBC
12 0000F5 FFFFB6
13 0000F3 FFFFB0
14 0000F1 FFFFAA
15 0000EF FFFFA4
16 0000ED FFFF9E
17 0000EA FFFF98
18 0000E7 FFFF93
19 0000E5 FFFF8D
20 0000E2 FFFF87
21 0000DF FFFF82
22 0000DC FFFF7C
23 0000D8 FFFF77
24 0000D5 FFFF72
25 0000D1 FFFF6D
26 0000CE FFFF68
27 0000CA FFFF63
28 0000C6 FFFF5E
29 0000C2 FFFF59
30 0000BE FFFF54
31 0000B9 FFFF4F
32 0000B5 FFFF4B
33 0000B1 FFFF47
34 0000AC FFFF42
35 0000A7 FFFF3E
36 0000A2 FFFF3A
37 00009D FFFF36
38 000098 FFFF32
39 000093 FFFF2F
40 00008E FFFF2B
41 000089 FFFF28
42 000084 FFFF24
43 00007E FFFF21
44 000079 FFFF1E
45 000073 FFFF1B
46 00006D FFFF19
47 000068 FFFF16
48 000062 FFFF13
49 00005C FFFF11
50 000056 FFFF0F
51 000050 FFFF0D
52 00004A FFFF0B
53 000044 FFFF09
54 00003E FFFF08
55 000038 FFFF06
56 000032 FFFF05
57 00002C FFFF04
58 000026 FFFF03
59 00001F FFFF02
60 000019 FFFF01
61 000013 FFFF01
62 00000D FFFF00
63 000006 FFFF00
64 000000 FFFF00
65 FFFFFA FFFF00
66 FFFFF3 FFFF00
67 FFFFED FFFF01
68 FFFFE7 FFFF01
69 FFFFE1 FFFF02
70 FFFFDA FFFF03
71 FFFFD4 FFFF04
72 FFFFCE FFFF05
73 FFFFC8 FFFF06
74 FFFFC2 FFFF08
75 FFFFBC FFFF09
76 FFFFB6 FFFF0B
77 FFFFB0 FFFF0D
78 FFFFAA FFFF0F
79 FFFFA4 FFFF11
80 FFFF9E FFFF13
81 FFFF98 FFFF16
82 FFFF93 FFFF19
83 FFFF8D FFFF1B
84 FFFF87 FFFF1E
85 FFFF82 FFFF21
86 FFFF7C FFFF24
87 FFFF77 FFFF28
88 FFFF72 FFFF2B
89 FFFF6D FFFF2F
90 FFFF68 FFFF32
91 FFFF63 FFFF36
92 FFFF5E FFFF3A
93 FFFF59 FFFF3E
94 FFFF54 FFFF42
95 FFFF4F FFFF47
96 FFFF4B FFFF4B
97 FFFF47 FFFF4F
98 FFFF42 FFFF54
99 FFFF3E FFFF59
100 FFFF3A FFFF5E
101 FFFF36 FFFF63
102 FFFF32 FFFF68
103 FFFF2F FFFF6D
104 FFFF2B FFFF72
105 FFFF28 FFFF77
106 FFFF24 FFFF7C
107 FFFF21 FFFF82
108 FFFF1E FFFF87
109 FFFF1B FFFF8D
110 FFFF19 FFFF93
111 FFFF16 FFFF98
112 FFFF13 FFFF9E
113 FFFF11 FFFFA4
114 FFFF0F FFFFAA
115 FFFF0D FFFFB0
116 FFFF0B FFFFB6
117 FFFF09 FFFFBC
118 FFFF08 FFFFC2
119 FFFF06 FFFFC8
120 FFFF05 FFFFCE
121 FFFF04 FFFFD4
122 FFFF03 FFFFDA
123 FFFF02 FFFFE1
124 FFFF01 FFFFE7
125 FFFF01 FFFFED
126 FFFF00 FFFFF3
127 FFFF00 FFFFFA

// File: compile.f
source/twiddle_pkg.sv
source/twiddle_sequencer.sv
source/twiddle_rom.sv
source/fft128_twiddle_gen.sv
sim/fft128_twiddle_gen_assertions.sv
sim/tb_fft128_twiddle_gen.sv

// File: Bender.yml
package:
  name: fft128_twiddle_gen

sources:
  # RTL, package first
  - files:
      - source/twiddle_pkg.sv
      - source/twiddle_sequencer.sv
      - source/twiddle_rom.sv
      - source/fft128_twiddle_gen.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/fft128_twiddle_gen_assertions.sv
      - sim/tb_fft128_twiddle_gen.sv
